// ==== include/axi_sram_settings.svh ====
// bus widths and memory depth for the AXI4 SRAM slave; include wherever these sizes are needed
`ifndef AXI_SRAM_SETTINGS_SVH
`define AXI_SRAM_SETTINGS_SVH

// AXI4 channel widths
`define AXI4_ID_WIDTH 4
`define AXI4_ADDR_WIDTH 32
`define AXI4_DATA_WIDTH 32
`define AXI4_WSTRB_WIDTH 4

// offset bits inside one 4 KB window
`define AXI4_ADDR_OFT_WIDTH 12
// log2 of bytes per data word
`define AXI4_DATA_BLOG 2

// default SRAM depth in words, 4 KB total
`define SRAM_WORDS 1024

`endif

// ==== design/axi4_pkg.sv ====
// AXI4 protocol encodings shared by the slave and its testbench; import where bursts or responses are used
package axi4_pkg;

  // AxBURST field encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10,
    // reserved code, answered with an error
    BURST_RSVD  = 2'b11
  } axi4_burst_t;

  // xRESP field encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    // exclusive access is not supported, never returned
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi4_resp_t;

endpackage

// ==== design/slv_pkg.sv ====
// internal types of the AXI4 slave state machine; import in modules that hold slave state
package slv_pkg;

  // slave FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT_W,
    ST_WRITE,
    ST_SEND_B
  } slv_state_t;

  // memory command issued in a given cycle
  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_READ,
    CMD_WRITE
  } mem_cmd_t;

endpackage

// ==== design/axi4_addr_gen.sv ====
// next-beat address calculation for AXI4 bursts inside a 4 KB window; used by the slave FSM
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module axi4_addr_gen
  import axi4_pkg::*;
(
  input  logic [7:0]                      alen_i,
  input  logic [2:0]                      asize_i,
  input  axi4_burst_t                     aburst_i,
  input  logic [`AXI4_ADDR_OFT_WIDTH-1:0] addr_i,
  output logic [`AXI4_ADDR_OFT_WIDTH-1:0] addr_o
);

  localparam int OFT_W = `AXI4_ADDR_OFT_WIDTH;

  logic [OFT_W-1:0] step;
  logic [OFT_W-1:0] aligned;
  logic [OFT_W-1:0] incr;
  logic [15:0]      wrap_bytes;
  logic [OFT_W-1:0] wrap_mask;

  // bytes per transfer
  assign step = OFT_W'(1) << asize_i;
  // later beats of an INCR burst are size aligned
  assign aligned = addr_i & ~(step - OFT_W'(1));
  assign incr = aligned + step;

  // total wrap window, size times beats
  assign wrap_bytes = (16'(alen_i) + 16'd1) << asize_i;
  assign wrap_mask = OFT_W'(wrap_bytes - 16'd1);

  always_comb begin
    case (aburst_i)
      BURST_INCR: addr_o = incr;
      // upper bits stay, lower bits roll over inside the window
      BURST_WRAP: addr_o = (addr_i & ~wrap_mask) | (incr & wrap_mask);
      // fixed and reserved keep the offset
      default: addr_o = addr_i;
    endcase
  end

  // a wrap burst must start on its transfer size and have 2, 4, 8 or 16 beats
  always_comb begin
    if (aburst_i == BURST_WRAP) begin
      assert ((addr_i & (step - OFT_W'(1))) == '0)
        else $error("wrap burst address not aligned to its size");
      assert (alen_i == 8'd1 || alen_i == 8'd3 || alen_i == 8'd7 || alen_i == 8'd15)
        else $error("wrap burst length is not 2, 4, 8 or 16");
    end
  end

endmodule

// ==== design/axi4_slv_fsm.sv ====
// AXI4 slave FSM turning read and write bursts into single-word SRAM accesses; used by the top level
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module axi4_slv_fsm
  import axi4_pkg::*;
  import slv_pkg::*;
(
  input  logic                                               aclk_i,
  input  logic                                               aresetn_i,
  // write address
  input  logic [`AXI4_ID_WIDTH-1:0]                          awid_i,
  input  logic [`AXI4_ADDR_WIDTH-1:0]                        awaddr_i,
  input  logic [7:0]                                         awlen_i,
  input  logic [2:0]                                         awsize_i,
  input  axi4_burst_t                                        awburst_i,
  input  logic                                               awvalid_i,
  output logic                                               awready_o,
  // write data
  input  logic [`AXI4_DATA_WIDTH-1:0]                        wdata_i,
  input  logic [`AXI4_WSTRB_WIDTH-1:0]                       wstrb_i,
  input  logic                                               wlast_i,
  input  logic                                               wvalid_i,
  output logic                                               wready_o,
  // write response
  output logic [`AXI4_ID_WIDTH-1:0]                          bid_o,
  output axi4_resp_t                                         bresp_o,
  output logic                                               bvalid_o,
  input  logic                                               bready_i,
  // read address
  input  logic [`AXI4_ID_WIDTH-1:0]                          arid_i,
  input  logic [`AXI4_ADDR_WIDTH-1:0]                        araddr_i,
  input  logic [7:0]                                         arlen_i,
  input  logic [2:0]                                         arsize_i,
  input  axi4_burst_t                                        arburst_i,
  input  logic                                               arvalid_i,
  output logic                                               arready_o,
  // read data
  output logic [`AXI4_ID_WIDTH-1:0]                          rid_o,
  output logic [`AXI4_DATA_WIDTH-1:0]                        rdata_o,
  output axi4_resp_t                                         rresp_o,
  output logic                                               rlast_o,
  output logic                                               rvalid_o,
  input  logic                                               rready_i,
  // memory port
  output logic                                               mem_en_o,
  output logic                                               mem_wen_o,
  output logic [`AXI4_ADDR_OFT_WIDTH-`AXI4_DATA_BLOG-1:0]    mem_addr_o,
  output logic [`AXI4_WSTRB_WIDTH-1:0]                       mem_bm_o,
  output logic [`AXI4_DATA_WIDTH-1:0]                        mem_wdata_o,
  input  logic [`AXI4_DATA_WIDTH-1:0]                        mem_rdata_i
);

  localparam int OFT_W = `AXI4_ADDR_OFT_WIDTH;

  slv_state_t                state_q, state_d;
  mem_cmd_t                  mem_cmd;
  // stored request
  logic [`AXI4_ID_WIDTH-1:0] req_id_q, req_id_d;
  logic [OFT_W-1:0]          req_addr_q, req_addr_d;
  logic [7:0]                req_len_q, req_len_d;
  logic [2:0]                req_size_q, req_size_d;
  axi4_burst_t               req_burst_q, req_burst_d;
  logic                      req_err_q, req_err_d;
  // beats done, up to 256
  logic [8:0]                beat_cnt_q, beat_cnt_d;
  logic [OFT_W-1:0]          next_addr;
  logic [OFT_W-1:0]          mem_oft;
  logic                      last_beat;
  logic                      ar_err, aw_err;
  logic                      ar_hs, aw_hs, w_hs, r_hs, b_hs;

  axi4_addr_gen u_axi4_addr_gen (
    .alen_i  (req_len_q),
    .asize_i (req_size_q),
    .aburst_i(req_burst_q),
    .addr_i  (req_addr_q),
    .addr_o  (next_addr)
  );

  // ready and valid come straight from the state
  assign arready_o = (state_q == ST_IDLE);
  // reads win over a write in the same cycle
  assign awready_o = (state_q == ST_IDLE) && !arvalid_i;
  // first W beat may ride along with AW
  assign wready_o = (state_q == ST_WAIT_W) || (state_q == ST_WRITE) ||
                    (awready_o && awvalid_i);
  assign rvalid_o = (state_q == ST_READ);
  assign bvalid_o = (state_q == ST_SEND_B);

  assign ar_hs = arvalid_i && arready_o;
  assign aw_hs = awvalid_i && awready_o;
  assign w_hs = wvalid_i && wready_o;
  assign r_hs = rvalid_o && rready_i;
  assign b_hs = bvalid_o && bready_i;

  assign ar_err = (arburst_i == BURST_RSVD);
  assign aw_err = (awburst_i == BURST_RSVD);
  assign last_beat = (beat_cnt_q == {1'b0, req_len_q} + 9'd1);

  // response side
  assign rid_o = req_id_q;
  assign bid_o = req_id_q;
  // error bursts return zero data
  assign rdata_o = req_err_q ? '0 : mem_rdata_i;
  assign rresp_o = req_err_q ? RESP_SLVERR : RESP_OKAY;
  assign bresp_o = req_err_q ? RESP_SLVERR : RESP_OKAY;
  assign rlast_o = rvalid_o && last_beat;

  // memory port
  assign mem_en_o = (mem_cmd != CMD_NONE);
  assign mem_wen_o = (mem_cmd == CMD_WRITE);
  assign mem_addr_o = mem_oft[OFT_W-1:`AXI4_DATA_BLOG];
  assign mem_bm_o = wstrb_i;
  assign mem_wdata_o = wdata_i;

  always_comb begin
    state_d     = state_q;
    req_id_d    = req_id_q;
    req_addr_d  = req_addr_q;
    req_len_d   = req_len_q;
    req_size_d  = req_size_q;
    req_burst_d = req_burst_q;
    req_err_d   = req_err_q;
    beat_cnt_d  = beat_cnt_q;
    mem_cmd     = CMD_NONE;
    mem_oft     = req_addr_q;
    case (state_q)
      ST_IDLE: begin
        if (ar_hs) begin
          req_id_d    = arid_i;
          req_addr_d  = araddr_i[OFT_W-1:0];
          req_len_d   = arlen_i;
          req_size_d  = arsize_i;
          req_burst_d = arburst_i;
          req_err_d   = ar_err;
          beat_cnt_d  = 9'd1;
          state_d     = ST_READ;
          // fetch beat one now so rvalid can rise next cycle
          mem_oft = araddr_i[OFT_W-1:0];
          if (!ar_err) begin
            mem_cmd = CMD_READ;
          end
        end else if (aw_hs) begin
          req_id_d    = awid_i;
          req_addr_d  = awaddr_i[OFT_W-1:0];
          req_len_d   = awlen_i;
          req_size_d  = awsize_i;
          req_burst_d = awburst_i;
          req_err_d   = aw_err;
          mem_oft     = awaddr_i[OFT_W-1:0];
          if (w_hs) begin
            beat_cnt_d = 9'd1;
            state_d = wlast_i ? ST_SEND_B : ST_WRITE;
            if (!aw_err) begin
              mem_cmd = CMD_WRITE;
            end
          end else begin
            // no beat written yet
            beat_cnt_d = 9'd0;
            state_d = ST_WAIT_W;
          end
        end
      end
      // address known, first data beat still missing
      ST_WAIT_W: begin
        if (w_hs) begin
          beat_cnt_d = 9'd1;
          state_d = wlast_i ? ST_SEND_B : ST_WRITE;
          if (!req_err_q) begin
            mem_cmd = CMD_WRITE;
          end
        end
      end
      // req_addr holds the last written beat, write goes to the next one
      ST_WRITE: begin
        mem_oft = next_addr;
        if (w_hs) begin
          req_addr_d = next_addr;
          beat_cnt_d = beat_cnt_q + 9'd1;
          if (!req_err_q) begin
            mem_cmd = CMD_WRITE;
          end
          if (wlast_i) begin
            state_d = ST_SEND_B;
          end
        end
      end
      // req_addr holds the beat on the bus
      ST_READ: begin
        if (r_hs) begin
          if (last_beat) begin
            state_d = ST_IDLE;
          end else begin
            mem_oft = next_addr;
            req_addr_d = next_addr;
            beat_cnt_d = beat_cnt_q + 9'd1;
            if (!req_err_q) begin
              mem_cmd = CMD_READ;
            end
          end
        end else if (!req_err_q) begin
          // stalled, read the same word again so rdata holds
          mem_cmd = CMD_READ;
        end
      end
      ST_SEND_B: begin
        if (b_hs) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk_i or negedge aresetn_i) begin
    if (!aresetn_i) begin
      state_q     <= ST_IDLE;
      req_id_q    <= '0;
      req_addr_q  <= '0;
      req_len_q   <= '0;
      req_size_q  <= '0;
      req_burst_q <= BURST_FIXED;
      req_err_q   <= 1'b0;
      beat_cnt_q  <= '0;
    end else begin
      state_q     <= state_d;
      req_id_q    <= req_id_d;
      req_addr_q  <= req_addr_d;
      req_len_q   <= req_len_d;
      req_size_q  <= req_size_d;
      req_burst_q <= req_burst_d;
      req_err_q   <= req_err_d;
      beat_cnt_q  <= beat_cnt_d;
    end
  end

  // a stalled R beat keeps its payload, which relies on the SRAM re-read
  assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rlast_o))
    else $error("R payload changed while stalled");

  assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    state_q == ST_READ |-> !wready_o)
    else $error("wready high during a read burst");

  // catches a master whose wlast disagrees with awlen
  assert property (@(posedge aclk_i) disable iff (!aresetn_i)
    state_q != ST_IDLE |-> beat_cnt_q <= {1'b0, req_len_q} + 9'd1)
    else $error("beat count beyond burst length");

endmodule

// ==== design/sram_bank.sv ====
// single-port SRAM with byte write mask and one cycle read latency; memory behind the AXI4 slave
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module sram_bank #(
  parameter int SRAM_DEPTH = `SRAM_WORDS
) (
  input  logic                                            aclk_i,
  input  logic                                            en_i,
  input  logic                                            wen_i,
  input  logic [`AXI4_ADDR_OFT_WIDTH-`AXI4_DATA_BLOG-1:0] addr_i,
  input  logic [`AXI4_WSTRB_WIDTH-1:0]                    bm_i,
  input  logic [`AXI4_DATA_WIDTH-1:0]                     wdata_i,
  output logic [`AXI4_DATA_WIDTH-1:0]                     rdata_o
);

  // word storage, contents undefined after power up
  logic [`AXI4_DATA_WIDTH-1:0] mem [SRAM_DEPTH];

  // byte lane writes, lanes with a clear mask bit keep old data
  always_ff @(posedge aclk_i) begin
    if (en_i && wen_i) begin
      for (int i = 0; i < `AXI4_WSTRB_WIDTH; i++) begin
        if (bm_i[i]) begin
          mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  // registered read port
  // data shows up the cycle after en_i, and holds while no read is issued
  always_ff @(posedge aclk_i) begin
    if (en_i && !wen_i) begin
      rdata_o <= mem[addr_i];
    end
  end

  // the window may be wider than a reduced depth
  assert property (@(posedge aclk_i) en_i |-> int'(addr_i) < SRAM_DEPTH)
    else $error("SRAM access beyond depth");

endmodule

// ==== design/axi_sram.sv ====
// top level of the AXI4 SRAM slave, FSM plus SRAM bank; this is the DUT the testbench instantiates
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module axi_sram
  import axi4_pkg::*;
(
  input  logic                          aclk_i,
  input  logic                          aresetn_i,
  input  logic [`AXI4_ID_WIDTH-1:0]     awid_i,
  input  logic [`AXI4_ADDR_WIDTH-1:0]   awaddr_i,
  input  logic [7:0]                    awlen_i,
  input  logic [2:0]                    awsize_i,
  input  axi4_burst_t                   awburst_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [`AXI4_DATA_WIDTH-1:0]   wdata_i,
  input  logic [`AXI4_WSTRB_WIDTH-1:0]  wstrb_i,
  input  logic                          wlast_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output logic [`AXI4_ID_WIDTH-1:0]     bid_o,
  output axi4_resp_t                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  input  logic [`AXI4_ID_WIDTH-1:0]     arid_i,
  input  logic [`AXI4_ADDR_WIDTH-1:0]   araddr_i,
  input  logic [7:0]                    arlen_i,
  input  logic [2:0]                    arsize_i,
  input  axi4_burst_t                   arburst_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output logic [`AXI4_ID_WIDTH-1:0]     rid_o,
  output logic [`AXI4_DATA_WIDTH-1:0]   rdata_o,
  output axi4_resp_t                    rresp_o,
  output logic                          rlast_o,
  output logic                          rvalid_o,
  input  logic                          rready_i
);

  // FSM to SRAM port
  logic                                            mem_en;
  logic                                            mem_wen;
  logic [`AXI4_ADDR_OFT_WIDTH-`AXI4_DATA_BLOG-1:0] mem_addr;
  logic [`AXI4_WSTRB_WIDTH-1:0]                    mem_bm;
  logic [`AXI4_DATA_WIDTH-1:0]                     mem_wdata;
  logic [`AXI4_DATA_WIDTH-1:0]                     mem_rdata;

  axi4_slv_fsm u_axi4_slv_fsm (
    .aclk_i     (aclk_i),
    .aresetn_i  (aresetn_i),
    .awid_i     (awid_i),
    .awaddr_i   (awaddr_i),
    .awlen_i    (awlen_i),
    .awsize_i   (awsize_i),
    .awburst_i  (awburst_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wlast_i    (wlast_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .bid_o      (bid_o),
    .bresp_o    (bresp_o),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .arid_i     (arid_i),
    .araddr_i   (araddr_i),
    .arlen_i    (arlen_i),
    .arsize_i   (arsize_i),
    .arburst_i  (arburst_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .rid_o      (rid_o),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rlast_o    (rlast_o),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .mem_en_o   (mem_en),
    .mem_wen_o  (mem_wen),
    .mem_addr_o (mem_addr),
    .mem_bm_o   (mem_bm),
    .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata)
  );

  // full 4 KB behind the slave
  sram_bank #(
    .SRAM_DEPTH(`SRAM_WORDS)
  ) u_sram_bank (
    .aclk_i (aclk_i),
    .en_i   (mem_en),
    .wen_i  (mem_wen),
    .addr_i (mem_addr),
    .bm_i   (mem_bm),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

endmodule

// ==== tb/tb_axi_sram.sv ====
// testbench for the AXI4 SRAM slave; burst tasks drive the bus, assertions check R and B beats
`timescale 1ns/1ps
`include "axi_sram_settings.svh"

module tb_axi_sram
  import axi4_pkg::*;
();

  localparam int N_TESTS = 60;
  localparam int MAX_BEATS = 256;
  localparam int WATCHDOG_CYCLES = N_TESTS * MAX_BEATS * 20;
  localparam int WIN_BYTES = 1 << `AXI4_ADDR_OFT_WIDTH;

  logic                          aclk;
  logic                          aresetn;
  logic [`AXI4_ID_WIDTH-1:0]     awid, arid, bid, rid;
  logic [`AXI4_ADDR_WIDTH-1:0]   awaddr, araddr;
  logic [7:0]                    awlen, arlen;
  logic [2:0]                    awsize, arsize;
  axi4_burst_t                   awburst, arburst;
  logic                          awvalid, awready, wvalid, wready, wlast;
  logic                          bvalid, bready, arvalid, arready;
  logic                          rvalid, rready, rlast;
  logic [`AXI4_DATA_WIDTH-1:0]   wdata, rdata;
  logic [`AXI4_WSTRB_WIDTH-1:0]  wstrb;
  axi4_resp_t                    bresp, rresp;

  // byte-wide reference copy of the 4 KB window
  logic [7:0]                    model [WIN_BYTES];
  logic [31:0]                   lcg_state;
  int                            err_cnt;
  int                            r_cnt;
  int                            b_cnt;
  // expectation for the burst in flight
  logic [`AXI4_ID_WIDTH-1:0]     exp_rid, exp_bid;
  logic [11:0]                   exp_addr;
  logic [7:0]                    exp_len;
  logic [2:0]                    exp_size;
  axi4_burst_t                   exp_burst;
  logic [8:0]                    exp_beat;
  axi4_resp_t                    exp_rresp, exp_bresp;
  logic [11:0]                   exp_wa;
  logic [`AXI4_DATA_WIDTH-1:0]   exp_word;

  axi_sram axi_sram_i (
    .aclk_i   (aclk),
    .aresetn_i(aresetn),
    .awid_i   (awid),
    .awaddr_i (awaddr),
    .awlen_i  (awlen),
    .awsize_i (awsize),
    .awburst_i(awburst),
    .awvalid_i(awvalid),
    .awready_o(awready),
    .wdata_i  (wdata),
    .wstrb_i  (wstrb),
    .wlast_i  (wlast),
    .wvalid_i (wvalid),
    .wready_o (wready),
    .bid_o    (bid),
    .bresp_o  (bresp),
    .bvalid_o (bvalid),
    .bready_i (bready),
    .arid_i   (arid),
    .araddr_i (araddr),
    .arlen_i  (arlen),
    .arsize_i (arsize),
    .arburst_i(arburst),
    .arvalid_i(arvalid),
    .arready_o(arready),
    .rid_o    (rid),
    .rdata_o  (rdata),
    .rresp_o  (rresp),
    .rlast_o  (rlast),
    .rvalid_o (rvalid),
    .rready_i (rready)
  );

  always #4 aclk = ~aclk;

  // error bursts read back as zero
  assign exp_wa = {exp_addr[11:2], 2'b00};
  assign exp_word = (exp_rresp == RESP_SLVERR) ? '0 :
                    {model[exp_wa + 12'd3], model[exp_wa + 12'd2],
                     model[exp_wa + 12'd1], model[exp_wa]};

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // next beat offset, straight from the AXI4 burst rules
  function automatic logic [11:0] beat_next(logic [11:0] addr, logic [7:0] len,
                                            logic [2:0] size, axi4_burst_t burst);
    int nbytes;
    int wrap_len;
    int base;
    int nxt;
    nbytes = 1 << size;
    nxt = (int'(addr) / nbytes) * nbytes + nbytes;
    if (burst == BURST_INCR) begin
      return 12'(nxt);
    end else if (burst == BURST_WRAP) begin
      wrap_len = nbytes * (int'(len) + 1);
      base = (int'(addr) / wrap_len) * wrap_len;
      if (nxt >= base + wrap_len) nxt = base;
      return 12'(nxt);
    end
    return addr;
  endfunction

  // byte lanes a narrow transfer may touch
  function automatic logic [3:0] lane_mask(logic [11:0] addr, logic [2:0] size);
    if (size >= 3'd2) return 4'hF;
    if (size == 3'd1) return 4'b0011 << {addr[1], 1'b0};
    return 4'b0001 << addr[1:0];
  endfunction

  task automatic write_burst(input logic [3:0] id, input logic [11:0] addr,
                             input logic [7:0] len, input logic [2:0] size,
                             input axi4_burst_t burst, input bit rnd_strb, input bit gaps);
    logic [11:0] baddr;
    logic [11:0] wa;
    logic [31:0] rs;
    bit          hs;
    exp_bid = id;
    exp_bresp = (burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;
    @(negedge aclk);
    fork
      begin
        awid = id;
        awaddr = `AXI4_ADDR_WIDTH'(addr);
        awlen = len;
        awsize = size;
        awburst = burst;
        awvalid = 1'b1;
        #1;
        while (!awready) begin
          @(negedge aclk);
          #1;
        end
        @(negedge aclk);
        awvalid = 1'b0;
      end
      begin
        baddr = addr;
        for (int b = 0; b <= int'(len); b++) begin
          // idle cycle on W, also before the first beat
          if (gaps && rand32() % 4 == 0) begin
            wvalid = 1'b0;
            @(negedge aclk);
          end
          rs = rand32();
          wdata = rand32();
          wstrb = rnd_strb ? (rs[7:4] & lane_mask(baddr, size)) : lane_mask(baddr, size);
          wlast = (b == int'(len));
          wvalid = 1'b1;
          #1;
          while (!wready) begin
            @(negedge aclk);
            #1;
          end
          // reserved bursts leave memory alone
          if (burst != BURST_RSVD) begin
            wa = {baddr[11:2], 2'b00};
            for (int i = 0; i < 4; i++) begin
              if (wstrb[i]) model[wa + 12'(i)] = wdata[i*8 +: 8];
            end
          end
          baddr = beat_next(baddr, len, size, burst);
          @(negedge aclk);
        end
        wvalid = 1'b0;
        wlast = 1'b0;
      end
    join
    hs = 1'b0;
    while (!hs) begin
      bready = (gaps && rand32() % 3 == 0) ? 1'b0 : 1'b1;
      #1;
      hs = bvalid && bready;
      @(negedge aclk);
    end
    bready = 1'b0;
    b_cnt++;
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [11:0] addr,
                            input logic [7:0] len, input logic [2:0] size,
                            input axi4_burst_t burst, input bit gaps);
    bit hs;
    bit done;
    exp_rid = id;
    exp_addr = addr;
    exp_len = len;
    exp_size = size;
    exp_burst = burst;
    exp_beat = 9'd0;
    exp_rresp = (burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;
    @(negedge aclk);
    arid = id;
    araddr = `AXI4_ADDR_WIDTH'(addr);
    arlen = len;
    arsize = size;
    arburst = burst;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge aclk);
      #1;
    end
    @(negedge aclk);
    arvalid = 1'b0;
    done = 1'b0;
    while (!done) begin
      rready = (gaps && rand32() % 3 == 0) ? 1'b0 : 1'b1;
      #1;
      hs = rvalid && rready;
      done = hs && rlast;
      @(negedge aclk);
      // step the expectation once the beat has gone
      if (hs) begin
        exp_addr = beat_next(exp_addr, exp_len, exp_size, exp_burst);
        exp_beat = exp_beat + 9'd1;
        r_cnt++;
      end
    end
    rready = 1'b0;
  endtask

  // every R beat against the model, its ID, response and last flag
  assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid |-> rdata == exp_word && rresp == exp_rresp && rid == exp_rid &&
               rlast == (exp_beat == {1'b0, exp_len}))
    else begin
      err_cnt++;
      $display("ERR %0t: R beat %0d at 0x%03h got %08h resp %0d last %0b, expected %08h",
               $time, exp_beat, exp_addr, $sampled(rdata), $sampled(rresp),
               $sampled(rlast), exp_word);
    end

  // stalled beats hold their payload
  assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
    else begin
      err_cnt++;
      $display("ERR %0t: R beat changed or dropped while rready was low", $time);
    end

  assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid |-> bid == exp_bid && bresp == exp_bresp)
    else begin
      err_cnt++;
      $display("ERR %0t: B got id %0h resp %0d, expected id %0h resp %0d",
               $time, $sampled(bid), $sampled(bresp), exp_bid, exp_bresp);
    end

  // address readies only between bursts, awready yields to a pending read
  assert property (@(posedge aclk) disable iff (!aresetn)
    !(arvalid && awready) && !((arready || awready) && (rvalid || bvalid)) &&
    !(rvalid && wready))
    else begin
      err_cnt++;
      $display("ERR %0t: ready or valid high outside its bus phase", $time);
    end

  assert property (@(posedge aclk) !aresetn |-> !rvalid && !bvalid && !wready)
    else begin
      err_cnt++;
      $display("ERR %0t: handshake output high during reset", $time);
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("timeout: a bus transfer did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [11:0] a;
    logic [7:0]  l;
    logic [31:0] r;
    aclk = 1'b0;
    aresetn = 1'b0;
    lcg_state = 32'd89494;
    err_cnt = 0;
    r_cnt = 0;
    b_cnt = 0;
    exp_rresp = RESP_OKAY;
    exp_bresp = RESP_OKAY;
    exp_addr = '0;
    exp_beat = '0;
    exp_len = '0;
    exp_rid = '0;
    exp_bid = '0;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awsize = '0;
    awburst = BURST_INCR;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arid = '0;
    araddr = '0;
    arlen = '0;
    arsize = '0;
    arburst = BURST_INCR;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // known contents for the whole window
    for (int k = 0; k < 4; k++) begin
      write_burst(4'(k), 12'(k * 1024), 8'd255, 3'd2, BURST_INCR, 1'b0, 1'b0);
    end
    // single beat, different IDs on each side
    write_burst(4'h5, 12'h100, 8'd0, 3'd2, BURST_INCR, 1'b0, 1'b0);
    read_burst(4'hA, 12'h100, 8'd0, 3'd2, BURST_INCR, 1'b0);

    // INCR with random lengths and strobes, kept inside the window
    for (int t = 0; t < 12; t++) begin
      r = rand32();
      l = 8'(r % 16);
      a = 12'((r >> 8) % (WIN_BYTES - (int'(l) + 1) * 4)) & 12'hFFC;
      write_burst(4'(r >> 4), a, l, 3'd2, BURST_INCR, 1'b1, 1'b0);
      read_burst(4'(r >> 12), a, l, 3'd2, BURST_INCR, 1'b0);
    end
    // narrow transfers, byte from an odd offset then halfword
    write_burst(4'h1, 12'h203, 8'd9, 3'd0, BURST_INCR, 1'b1, 1'b0);
    read_burst(4'h2, 12'h203, 8'd9, 3'd0, BURST_INCR, 1'b0);
    write_burst(4'h1, 12'h302, 8'd5, 3'd1, BURST_INCR, 1'b1, 1'b0);
    read_burst(4'h2, 12'h302, 8'd5, 3'd1, BURST_INCR, 1'b0);

    // WRAP starting two words into its window
    for (int t = 0; t < 2; t++) begin
      l = (t == 0) ? 8'd3 : 8'd7;
      a = 12'h400 + 12'(t * 64) + 12'd8;
      write_burst(4'h3, a, l, 3'd2, BURST_WRAP, 1'b0, 1'b0);
      read_burst(4'h4, a - 12'd8, l, 3'd2, BURST_INCR, 1'b0);
      read_burst(4'h6, a, l, 3'd2, BURST_WRAP, 1'b0);
    end

    // FIXED, only the last beat should survive
    write_burst(4'h7, 12'h800, 8'd3, 3'd2, BURST_FIXED, 1'b0, 1'b0);
    read_burst(4'h8, 12'h7FC, 8'd2, 3'd2, BURST_INCR, 1'b0);
    read_burst(4'h8, 12'h800, 8'd3, 3'd2, BURST_FIXED, 1'b0);

    // back-pressure on W, R and B
    for (int t = 0; t < 6; t++) begin
      r = rand32();
      l = 8'(r % 32);
      a = 12'((r >> 8) % (WIN_BYTES - (int'(l) + 1) * 4)) & 12'hFFC;
      write_burst(4'(r >> 4), a, l, 3'd2, BURST_INCR, 1'b1, 1'b1);
      read_burst(4'(r >> 12), a, l, 3'd2, BURST_INCR, 1'b1);
    end

    // reserved encoding, memory must stay as it was
    write_burst(4'h9, 12'hA00, 8'd3, 3'd2, BURST_RSVD, 1'b0, 1'b0);
    read_burst(4'hB, 12'hA00, 8'd3, 3'd2, BURST_INCR, 1'b0);
    read_burst(4'hC, 12'hA00, 8'd5, 3'd2, BURST_RSVD, 1'b1);

    repeat (4) @(negedge aclk);
    $display("done: %0d R beats, %0d B responses, %0d errors", r_cnt, b_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== axi_sram.f ====
+incdir+include
design/axi4_pkg.sv
design/slv_pkg.sv
design/axi4_addr_gen.sv
design/axi4_slv_fsm.sv
design/sram_bank.sv
design/axi_sram.sv
tb/tb_axi_sram.sv

// ==== Makefile ====
# Verilator build and run of the AXI4 SRAM slave testbench
VERILATOR  ?= verilator
TOP        ?= tb_axi_sram
FILELIST   ?= axi_sram.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Result: PASSED
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := include/axi_sram_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, so a crashed run also fails
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
